// ==== Makefile ====
# Verilator build and run for the decode branch block
# any variable below can be overridden, e.g. make run JOBS=4

VERILATOR ?= verilator
TOP       ?= tb_decode_branch
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing -j $(JOBS)

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard verilog/*.sv) $(wildcard tb/*.sv) $(wildcard tb/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the simulator exits non-zero on $$fatal, so make fails with it
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

// ==== compile.f ====
+incdir+tb
verilog/wisc_pkg.sv
verilog/dest_decode.sv
verilog/stage_regs.sv
verilog/decode_forward.sv
verilog/branch_unit.sv
verilog/decode_branch_top.sv
tb/tb_decode_branch.sv

// ==== tb/ref_model.svh ====
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

// model copies of the entries held in execute and memory
wisc_pkg::stage_info_t model_e;
wisc_pkg::stage_info_t model_m;

// destination of one instruction, worked out from the opcode groups
function automatic wisc_pkg::stage_info_t model_dest(input wisc_pkg::word_t instr);
  wisc_pkg::stage_info_t s;
  wisc_pkg::opcode_t     op;
  s       = '0;
  op      = instr[15:11];
  s.instr = instr;
  if (op >= 5'b11010) begin  // R-format group, Rd in bits 4 to 2
    s.dest      = instr[4:2];
    s.reg_write = 1'b1;
    s.valid_rd  = 1'b1;
  end else if (op[4:2] == 3'b010 || op[4:2] == 3'b101 || op == wisc_pkg::ld) begin
    s.dest      = instr[7:5];
    s.reg_write = 1'b1;
    s.valid_rd  = 1'b1;
  end else if (op == wisc_pkg::stu || op == wisc_pkg::slbi || op == wisc_pkg::lbi) begin
    s.dest      = instr[10:8];  // these write back through Rs
    s.reg_write = 1'b1;
    s.writes_rs = 1'b1;
  end else if (op == wisc_pkg::jal || op == wisc_pkg::jalr) begin
    s.dest      = wisc_pkg::r7;
    s.reg_write = 1'b1;
    s.writes_r7 = 1'b1;
  end
  return s;
endfunction

function automatic logic is_load(input wisc_pkg::word_t instr);
  return instr[15:11] == wisc_pkg::ld;
endfunction

// a stage holds register rs if any of its write kinds lands there
// a load still in execute only has its address, so it is skipped there
function automatic logic stage_supplies(input wisc_pkg::stage_info_t s,
                                        input wisc_pkg::reg_idx_t rs, input logic in_ex);
  logic rd_ok;
  rd_ok = s.valid_rd && s.reg_write && !(in_ex && is_load(s.instr));
  return (rd_ok && s.dest == rs) || (s.writes_rs && s.dest == rs) ||
         (s.writes_r7 && rs == wisc_pkg::r7);
endfunction

// both stages write one register, except the case of two link writes
function automatic logic model_take_ex(input wisc_pkg::stage_info_t e,
                                       input wisc_pkg::stage_info_t m);
  logic e_on;
  logic m_on;
  e_on = (e.valid_rd && e.reg_write && !is_load(e.instr)) || e.writes_rs || e.writes_r7;
  m_on = (m.valid_rd && m.reg_write) || m.writes_rs || m.writes_r7;
  return e_on && m_on && (e.dest == m.dest) && !(e.writes_r7 && m.writes_r7);
endfunction

// Rs value that the decode branch should see
function automatic wisc_pkg::word_t model_forward(
    input wisc_pkg::word_t instr, input wisc_pkg::stage_info_t e,
    input wisc_pkg::stage_info_t m, input wisc_pkg::word_t exd,
    input wisc_pkg::word_t maddr, input wisc_pkg::word_t mrd, input wisc_pkg::word_t drs);
  wisc_pkg::opcode_t  op;
  wisc_pkg::reg_idx_t rs;
  logic               branch;
  logic               suppressed;
  op         = instr[15:11];
  rs         = instr[10:8];
  branch     = op inside {wisc_pkg::beqz, wisc_pkg::bnez, wisc_pkg::bltz, wisc_pkg::bgez,
                          wisc_pkg::jr, wisc_pkg::jalr};
  suppressed = op inside {wisc_pkg::jalr, wisc_pkg::j, wisc_pkg::nop, wisc_pkg::lbi,
                          wisc_pkg::halt, wisc_pkg::siic, wisc_pkg::rti};
  if (!branch || suppressed) return drs;
  if (stage_supplies(m, rs, 1'b0) && !model_take_ex(e, m)) begin
    return is_load(m.instr) ? mrd : maddr;  // load data only exists in memory
  end
  if (stage_supplies(e, rs, 1'b1)) return exd;
  return drs;
endfunction

// outcome that should show up one cycle after decode
function automatic wisc_pkg::branch_result_t model_result(input wisc_pkg::word_t instr,
    input wisc_pkg::word_t pc, input wisc_pkg::word_t rs_val);
  wisc_pkg::branch_result_t r;
  wisc_pkg::word_t          imm;
  r   = '0;
  imm = {{8{instr[7]}}, instr[7:0]};
  r.valid  = 1'b1;
  r.target = pc + 16'd2 + imm;  // pc relative unless a register jump below
  case (instr[15:11])
    wisc_pkg::beqz: r.taken = (rs_val == 16'd0);
    wisc_pkg::bnez: r.taken = (rs_val != 16'd0);
    wisc_pkg::bltz: r.taken = rs_val[15];
    wisc_pkg::bgez: r.taken = !rs_val[15];
    wisc_pkg::jr, wisc_pkg::jalr: begin
      r.taken  = 1'b1;
      r.target = rs_val + imm;
    end
    default: r = '0;  // not a branch, nothing valid
  endcase
  return r;
endfunction

`endif

// ==== tb/tb_decode_branch.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_decode_branch;

  localparam int clk_period = 4;     // ns
  localparam int num_cycles = 3000;  // random cycles after reset
  localparam int timeout_ns = (num_cycles + 20) * clk_period + 100;

  logic                     clk;
  logic                     rst_n;
  wisc_pkg::word_t          instr_d;
  wisc_pkg::word_t          pc_d;
  wisc_pkg::word_t          data_rs;
  wisc_pkg::word_t          execute_data;
  wisc_pkg::word_t          mem_address;
  wisc_pkg::word_t          memory_read_data;
  wisc_pkg::branch_result_t result;

  wisc_pkg::branch_result_t expected;  // prediction for last cycle's decode instruction
  logic [31:0]              rng_state;
  int                       branch_count;

  `include "ref_model.svh"

  decode_branch_top i_dut (
    .clk              (clk),
    .rst_n            (rst_n),
    .instr_d          (instr_d),
    .pc_d             (pc_d),
    .data_rs          (data_rs),
    .execute_data     (execute_data),
    .mem_address      (mem_address),
    .memory_read_data (memory_read_data),
    .result           (result)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // opcodes lean toward branches, link writers, Rs writers and loads
  function automatic wisc_pkg::opcode_t pick_opcode(input logic [31:0] r);
    wisc_pkg::opcode_t op;
    if (r[3:0] < 4'd6) begin
      case (r[6:4])
        3'd0:       op = wisc_pkg::beqz;
        3'd1:       op = wisc_pkg::bnez;
        3'd2:       op = wisc_pkg::bltz;
        3'd3:       op = wisc_pkg::bgez;
        3'd4, 3'd5: op = wisc_pkg::jr;
        default:    op = wisc_pkg::jalr;
      endcase
    end else if (r[3:0] < 4'd8) begin
      op = r[4] ? wisc_pkg::jal : wisc_pkg::jalr;
    end else if (r[3:0] < 4'd10) begin
      op = (r[5:4] == 2'd0) ? wisc_pkg::stu : (r[5:4] == 2'd1) ? wisc_pkg::slbi : wisc_pkg::lbi;
    end else if (r[3:0] < 4'd12) begin
      op = wisc_pkg::ld;
    end else if (r[3:0] < 4'd14) begin
      case (r[7:5])  // arithmetic writers of Rd
        3'd0:    op = wisc_pkg::shift_r;
        3'd1:    op = wisc_pkg::alu_r;
        3'd2:    op = wisc_pkg::seq;
        3'd3:    op = wisc_pkg::slt;
        3'd4:    op = wisc_pkg::sle;
        3'd5:    op = wisc_pkg::sco;
        3'd6:    op = {3'b010, r[9:8]};
        default: op = {3'b101, r[9:8]};
      endcase
    end else if (r[3:0] == 4'd14) begin
      case (r[6:4])  // instructions that write nothing
        3'd0:    op = wisc_pkg::halt;
        3'd1:    op = wisc_pkg::siic;
        3'd2:    op = wisc_pkg::rti;
        3'd3:    op = wisc_pkg::j;
        3'd4:    op = wisc_pkg::st;
        3'd5:    op = 5'b11001;
        default: op = wisc_pkg::nop;
      endcase
    end else begin
      op = r[8:4];  // anything at all
    end
    return op;
  endfunction

  // few registers so that matches between stages happen often
  function automatic wisc_pkg::reg_idx_t pick_reg(input logic [1:0] r);
    case (r)
      2'd0:    return 3'd1;
      2'd1:    return 3'd2;
      default: return wisc_pkg::r7;
    endcase
  endfunction

  function automatic wisc_pkg::word_t pick_data(input logic [31:0] r);
    return (r[1:0] == 2'd0) ? 16'd0 : r[31:16];  // zero often enough for beqz and bnez
  endfunction

  task automatic drive_inputs();
    logic [31:0] r_op;
    logic [31:0] r_fld;
    logic [31:0] r_pc;
    r_op  = next_rand();
    r_fld = next_rand();
    r_pc  = next_rand();
    instr_d = {pick_opcode(r_op), pick_reg(r_fld[1:0]), pick_reg(r_fld[3:2]),
               pick_reg(r_fld[5:4]), r_fld[7:6]};
    if (r_fld[8]) instr_d[7:0] = r_fld[23:16];  // wider spread of branch offsets
    pc_d             = {r_pc[15:1], 1'b0};
    data_rs          = pick_data(next_rand());
    execute_data     = pick_data(next_rand());
    mem_address      = pick_data(next_rand());
    memory_read_data = pick_data(next_rand());
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s got 0x%0h, expected 0x%0h", $time, what, got, exp);
      $display("Checks failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic compare_result();
    check_value(32'(result.valid), 32'(expected.valid), "result.valid");
    if (expected.valid) begin  // taken and target only mean something with valid
      check_value(32'(result.taken), 32'(expected.taken), "result.taken");
      check_value(32'(result.target), 32'(expected.target), "result.target");
      branch_count++;
    end
  endtask

  initial begin
    rng_state        = 32'h17eb_0d0d;
    branch_count     = 0;
    rst_n            = 1'b0;
    instr_d          = {wisc_pkg::nop, 11'd0};
    pc_d             = '0;
    data_rs          = '0;
    execute_data     = '0;
    mem_address      = '0;
    memory_read_data = '0;
    expected         = '0;  // nothing valid straight out of reset
    model_e          = model_dest({wisc_pkg::nop, 11'd0});
    model_m          = model_e;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int cyc = 0; cyc < num_cycles; cyc++) begin
      compare_result();  // result for the instruction driven one edge ago
      drive_inputs();
      expected = model_result(instr_d, pc_d,
                              model_forward(instr_d, model_e, model_m, execute_data,
                                            mem_address, memory_read_data, data_rs));
      model_m = model_e;  // the edge below shifts the pipeline
      model_e = model_dest(instr_d);
      @(posedge clk);
      #1;
    end
    compare_result();
    $display("resolved %0d branches and jumps", branch_count);
    $display("All checks passed");
    $finish;
  end

  // the stimulus loop has a fixed length, so a late run means a hang
  initial begin
    #(timeout_ns);
    $display("watchdog expired before the stimulus loop finished");
    $display("Checks failed");
    $fatal(1, "simulation timed out");
  end

endmodule

`default_nettype wire

// ==== verilog/branch_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module branch_unit (
  input  logic                     clk,
  input  logic                     rst_n,
  input  wisc_pkg::word_t          instr_d,   // instruction in decode
  input  wisc_pkg::word_t          pc_d,      // its address
  input  wisc_pkg::word_t          rs_value,  // forwarded Rs
  output wisc_pkg::branch_result_t result     // outcome one cycle later
);

  wisc_pkg::opcode_t        opcode;
  wisc_pkg::word_t          imm_ext;      // bits 7 to 0 sign extended
  wisc_pkg::word_t          cond_target;  // pc relative target
  wisc_pkg::word_t          jump_target;  // register relative target
  logic                     is_cond, is_jump;
  logic                     cond_true;
  wisc_pkg::branch_result_t result_nxt;

  assign opcode  = instr_d[15:11];
  assign imm_ext = {{8{instr_d[7]}}, instr_d[7:0]};

  assign is_cond = (opcode == wisc_pkg::beqz) | (opcode == wisc_pkg::bnez) |
                   (opcode == wisc_pkg::bltz) | (opcode == wisc_pkg::bgez);
  assign is_jump = (opcode == wisc_pkg::jr) | (opcode == wisc_pkg::jalr);

  // branches are relative to the next sequential pc
  assign cond_target = pc_d + 16'd2 + imm_ext;
  assign jump_target = rs_value + imm_ext;

  // test Rs against zero as the opcode asks
  always_comb begin
    case (opcode)
      wisc_pkg::beqz: cond_true = (rs_value == '0);
      wisc_pkg::bnez: cond_true = (rs_value != '0);
      wisc_pkg::bltz: cond_true = rs_value[15];   // sign bit set
      wisc_pkg::bgez: cond_true = ~rs_value[15];
      default:        cond_true = 1'b0;
    endcase
  end

  always_comb begin
    result_nxt.valid  = is_cond | is_jump;
    result_nxt.taken  = is_jump | (is_cond & cond_true);  // register jumps always go
    if (is_jump) begin
      result_nxt.target = jump_target;
    end else if (is_cond) begin
      result_nxt.target = cond_target;  // reported even when not taken
    end else begin
      result_nxt.target = '0;           // nothing to report for other opcodes
    end
  end

  // one register stage, the result belongs to last cycle's decode instruction
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result <= '0;
    end else begin
      result <= result_nxt;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/decode_branch_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module decode_branch_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  wisc_pkg::word_t          instr_d,           // instruction in decode
  input  wisc_pkg::word_t          pc_d,              // pc of that instruction
  input  wisc_pkg::word_t          data_rs,           // register file read of Rs
  input  wisc_pkg::word_t          execute_data,      // belongs to the execute entry
  input  wisc_pkg::word_t          mem_address,       // belongs to the memory entry
  input  wisc_pkg::word_t          memory_read_data,  // load data of the memory entry
  output wisc_pkg::branch_result_t result             // branch outcome, one cycle late
);

  wisc_pkg::stage_info_t info_d;       // destination summary of the decode instruction
  wisc_pkg::stage_info_t info_e;
  wisc_pkg::stage_info_t info_m;
  wisc_pkg::word_t       data_rs_fwd;  // Rs after forwarding

  // work out what the decode instruction will write
  dest_decode i_dest_decode (
    .instr (instr_d),
    .info  (info_d)
  );

  // keep that summary for the two stages behind decode
  stage_regs i_stage_regs (
    .clk    (clk),
    .rst_n  (rst_n),
    .info_d (info_d),
    .info_e (info_e),
    .info_m (info_m)
  );

  // pick the newest copy of Rs
  decode_forward i_decode_forward (
    .instr_d          (instr_d),
    .info_e           (info_e),
    .info_m           (info_m),
    .execute_data     (execute_data),
    .mem_address      (mem_address),
    .memory_read_data (memory_read_data),
    .data_rs          (data_rs),
    .data_rs_fwd      (data_rs_fwd)
  );

  // resolve in decode and register the outcome
  branch_unit i_branch_unit (
    .clk      (clk),
    .rst_n    (rst_n),
    .instr_d  (instr_d),
    .pc_d     (pc_d),
    .rs_value (data_rs_fwd),
    .result   (result)
  );

endmodule

`default_nettype wire

// ==== verilog/decode_forward.sv ====
`timescale 1ns/100ps
`default_nettype none

module decode_forward (
  input  wisc_pkg::word_t       instr_d,           // instruction in decode
  input  wisc_pkg::stage_info_t info_e,            // writer one ahead
  input  wisc_pkg::stage_info_t info_m,            // writer two ahead
  input  wisc_pkg::word_t       execute_data,      // alu result of the execute instruction
  input  wisc_pkg::word_t       mem_address,       // alu result carried into memory
  input  wisc_pkg::word_t       memory_read_data,  // load data of the memory instruction
  input  wisc_pkg::word_t       data_rs,           // register file read of Rs
  output wisc_pkg::word_t       data_rs_fwd        // newest Rs value for the branch unit
);

  wisc_pkg::opcode_t  opcode_d;
  wisc_pkg::reg_idx_t rs_d;
  logic load_e, load_m;
  logic ex_write_rd, ex_write_rs, ex_write_r7;
  logic mem_write_rd, mem_write_rs, mem_write_r7;
  logic branch, no_forward;
  logic take_ex;
  logic [7:0] overlap;  // one bit per case where both stages write the same register
  logic replace_ex, replace_mem;

  assign opcode_d = instr_d[15:11];
  assign rs_d     = instr_d[10:8];  // Rs field of the decode instruction

  // a load in execute has no data yet, only its address
  assign load_e = (info_e.instr[15:11] == wisc_pkg::ld);
  assign load_m = (info_m.instr[15:11] == wisc_pkg::ld);

  // execute stage writer kinds
  assign ex_write_rd = info_e.valid_rd & info_e.reg_write & ~load_e;
  assign ex_write_rs = info_e.writes_rs;
  assign ex_write_r7 = info_e.writes_r7;

  // memory stage writer kinds, loads included since read data is available
  assign mem_write_rd = info_m.valid_rd & info_m.reg_write;
  assign mem_write_rs = info_m.writes_rs;
  assign mem_write_r7 = info_m.writes_r7;

  // only conditional branches and register jumps read Rs in decode
  assign branch = (opcode_d == wisc_pkg::beqz) | (opcode_d == wisc_pkg::bnez) |
                  (opcode_d == wisc_pkg::bltz) | (opcode_d == wisc_pkg::bgez) |
                  (opcode_d == wisc_pkg::jr)   | (opcode_d == wisc_pkg::jalr);

  // opcodes whose Rs field is not a real source
  assign no_forward = (opcode_d == wisc_pkg::jalr) | (opcode_d == wisc_pkg::j)   |
                      (opcode_d == wisc_pkg::nop)  | (opcode_d == wisc_pkg::lbi) |
                      (opcode_d == wisc_pkg::halt) | (opcode_d == wisc_pkg::siic) |
                      (opcode_d == wisc_pkg::rti);

  // both stages hit the same register, the younger execute value must win
  assign overlap[0] = ex_write_rd & mem_write_rd & (info_e.dest == info_m.dest);
  assign overlap[1] = ex_write_rd & mem_write_rs & (info_e.dest == info_m.dest);
  assign overlap[2] = ex_write_rs & mem_write_rs & (info_e.dest == info_m.dest);
  assign overlap[3] = ex_write_rs & mem_write_rd & (info_e.dest == info_m.dest);
  // r7 cases where one side is a link write
  assign overlap[4] = ex_write_r7 & mem_write_rs & (info_m.dest == wisc_pkg::r7);
  assign overlap[5] = ex_write_r7 & mem_write_rd & (info_m.dest == wisc_pkg::r7);
  assign overlap[6] = mem_write_r7 & ex_write_rs & (info_e.dest == wisc_pkg::r7);
  assign overlap[7] = mem_write_r7 & ex_write_rd & (info_e.dest == wisc_pkg::r7);

  assign take_ex = |overlap;

  // does a stage hold the value that decode wants for Rs
  assign replace_ex  = ~no_forward &
                       (((rs_d == info_e.dest) & ex_write_rd) |
                        ((rs_d == info_e.dest) & ex_write_rs) |
                        ((rs_d == wisc_pkg::r7) & ex_write_r7));
  assign replace_mem = ~no_forward &
                       (((rs_d == info_m.dest) & mem_write_rd) |
                        ((rs_d == info_m.dest) & mem_write_rs) |
                        ((rs_d == wisc_pkg::r7) & mem_write_r7));

  // memory is checked first but yields to execute whenever take_ex is set
  always_comb begin
    if (branch & ~take_ex & replace_mem & load_m) begin
      data_rs_fwd = memory_read_data;  // load result in memory stage
    end else if (branch & ~take_ex & replace_mem) begin
      data_rs_fwd = mem_address;       // alu result two ahead
    end else if (branch & replace_ex) begin
      data_rs_fwd = execute_data;      // alu result one ahead
    end else begin
      data_rs_fwd = data_rs;           // register file is already current
    end
  end

endmodule

`default_nettype wire

// ==== verilog/dest_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module dest_decode (
  input  wisc_pkg::word_t       instr,  // instruction sitting in decode
  output wisc_pkg::stage_info_t info    // its destination summary
);

  wisc_pkg::opcode_t opcode;

  assign opcode = instr[15:11];

  always_comb begin
    info           = '0;     // no write unless an opcode below says so
    info.instr     = instr;  // carried along so later stages can spot loads
    casez (opcode)
      // R-format arithmetic, destination in bits 4 to 2
      wisc_pkg::shift_r, wisc_pkg::alu_r, wisc_pkg::seq,
      wisc_pkg::slt, wisc_pkg::sle, wisc_pkg::sco: begin
        info.dest      = instr[4:2];
        info.reg_write = 1'b1;
        info.valid_rd  = 1'b1;
      end
      // I-format arithmetic and ld put Rd in bits 7 to 5
      5'b010??, 5'b101??, wisc_pkg::ld: begin
        info.dest      = instr[7:5];
        info.reg_write = 1'b1;
        info.valid_rd  = 1'b1;
      end
      // these write back through their own Rs field
      wisc_pkg::stu, wisc_pkg::slbi, wisc_pkg::lbi: begin
        info.dest      = instr[10:8];
        info.reg_write = 1'b1;
        info.writes_rs = 1'b1;
      end
      wisc_pkg::jal, wisc_pkg::jalr: begin
        info.dest      = wisc_pkg::r7;  // link address always lands in r7
        info.reg_write = 1'b1;
        info.writes_r7 = 1'b1;
      end
      // control flow, stores, specials and btr leave the register file alone
      default: begin
        info.reg_write = 1'b0;  // anything unlisted is treated as a non writer too
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/stage_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module stage_regs (
  input  logic                  clk,
  input  logic                  rst_n,
  input  wisc_pkg::stage_info_t info_d,  // decode summary from dest_decode
  output wisc_pkg::stage_info_t info_e,  // instruction now in execute
  output wisc_pkg::stage_info_t info_m   // instruction now in memory
);

  // the pipeline never stalls here, so both slots advance on every edge
  // and an instruction spends exactly one cycle in each stage

  // decode to execute
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      info_e <= wisc_pkg::info_nop;  // empty slot, reg_write low
    end else begin
      info_e <= info_d;
    end
  end

  // execute to memory
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      info_m <= wisc_pkg::info_nop;
    end else begin
      info_m <= info_e;  // whatever was in execute moves on
    end
  end

  // the execute_data, mem_address and memory_read_data inputs at the top
  // level line up with info_e and info_m as held here, so the forwarding
  // unit can compare registers and pick values in the same cycle

endmodule

`default_nettype wire

// ==== verilog/wisc_pkg.sv ====
`default_nettype none

package wisc_pkg;

  typedef logic [15:0] word_t;     // one data value or one instruction
  typedef logic [2:0]  reg_idx_t;  // register number, eight registers in all
  typedef logic [4:0]  opcode_t;   // instruction bits 15 to 11

  // special and control flow opcodes
  localparam opcode_t halt = 5'b00000;
  localparam opcode_t nop  = 5'b00001;
  localparam opcode_t siic = 5'b00010;  // software interrupt
  localparam opcode_t rti  = 5'b00011;  // return from interrupt
  localparam opcode_t j    = 5'b00100;  // pc relative jump with no link
  localparam opcode_t jr   = 5'b00101;  // register jump, target is Rs plus imm8
  localparam opcode_t jal  = 5'b00110;  // pc relative jump that links into r7
  localparam opcode_t jalr = 5'b00111;  // register jump that links into r7

  // conditional branches all test Rs against zero
  localparam opcode_t beqz = 5'b01100;
  localparam opcode_t bnez = 5'b01101;
  localparam opcode_t bltz = 5'b01110;
  localparam opcode_t bgez = 5'b01111;

  // memory and immediate load opcodes
  localparam opcode_t st   = 5'b10000;  // store, writes no register
  localparam opcode_t ld   = 5'b10001;  // load into Rd at bits 7 to 5
  localparam opcode_t slbi = 5'b10010;  // shift and load byte into Rs
  localparam opcode_t stu  = 5'b10011;  // store with Rs update
  localparam opcode_t lbi  = 5'b11000;  // load byte immediate into Rs

  // R-format group writes Rd at bits 4 to 2
  localparam opcode_t shift_r = 5'b11010;  // register shifts and rotates
  localparam opcode_t alu_r   = 5'b11011;  // add, sub, xor, andn
  localparam opcode_t seq     = 5'b11100;
  localparam opcode_t slt     = 5'b11101;
  localparam opcode_t sle     = 5'b11110;
  localparam opcode_t sco     = 5'b11111;  // set on carry out

  localparam reg_idx_t r7 = 3'd7;  // link register written by jal and jalr

  // what later stages need to know about an instruction's write
  typedef struct packed {
    word_t    instr;      // whole instruction, opcode is kept for load checks
    reg_idx_t dest;       // register being written, zero when none
    logic     reg_write;  // instruction writes a register at all
    logic     valid_rd;   // dest came from a Rd-style field
    logic     writes_rs;  // dest is the Rs field (stu, slbi, lbi)
    logic     writes_r7;  // jal or jalr linking into r7
  } stage_info_t;

  // registered outcome of a decode-stage branch or jump
  typedef struct packed {
    logic  valid;   // a branch or jump was in decode last cycle
    logic  taken;
    word_t target;
  } branch_result_t;

  // empty pipeline slot used on reset
  localparam stage_info_t info_nop = '{
    instr:     word_t'({nop, 11'd0}),
    dest:      reg_idx_t'(0),
    reg_write: 1'b0,
    valid_rd:  1'b0,
    writes_rs: 1'b0,
    writes_r7: 1'b0
  };

endpackage

`default_nettype wire
